//--- Bender.yml
package:
  name: atc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/atc_pkg.sv
      - verilog/plane_fifo.sv
      - verilog/request_fsm.sv
      - verilog/runway_table.sv
      - verilog/reply_builder.sv
      - verilog/reply_sender.sv
      - verilog/atc_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/atc_tb.sv

//--- all.f
+incdir+verilog
verilog/atc_pkg.sv
verilog/plane_fifo.sv
verilog/request_fsm.sv
verilog/runway_table.sv
verilog/reply_builder.sv
verilog/reply_sender.sv
verilog/atc_top.sv
sim/atc_tb.sv

//--- sim/atc_tb.sv
// Testbench for the two-runway controller core.
// Drives directed and LFSR-random requests into atc_top, predicts every reply
// and the runway lock state with a queue-level model, and checks them.

`timescale 1ns/1ps
`include "atc_defs.svh"

module atc_tb;

  localparam int DIRECTED_REQUESTS = 32;
  localparam int FILL_REQUESTS     = 16;
  localparam int READY_REQUESTS    = 20;
  localparam int RANDOM_REQUESTS   = 200;
  localparam int CYCLE_LIMIT =
    (DIRECTED_REQUESTS + FILL_REQUESTS + READY_REQUESTS + RANDOM_REQUESTS) * 60 + 500;

  logic                    clock;
  logic                    reset;
  logic                    request_valid;
  atc_pkg::msg_t           request;
  logic                    busy;
  logic                    reply_valid;
  atc_pkg::msg_t           reply;
  logic                    reply_ready;
  logic [`ATC_RUNWAYS-1:0] runway_active;

  // Reference model state
  atc_pkg::msg_t              expected [$];
  logic [`ATC_PLANE_ID_W-1:0] takeoff_q [$];
  logic [`ATC_PLANE_ID_W-1:0] landing_q [$];
  logic [`ATC_PLANE_ID_W-1:0] owner [`ATC_RUNWAYS];
  logic [`ATC_RUNWAYS-1:0]    active;
  logic                       emergency_flag;
  logic                       takeoff_first;

  logic [31:0] lfsr_state = 32'hd28c9745;
  int          errors = 0;
  int          checks = 0;
  int          quiet_cycles = 0;
  int          cycle_count = 0;
  int          errors_before;
  logic        ready_random = 1'b0;
  logic        ready_seen = 1'b1;
  logic        valid_seen = 1'b0;

  atc_top DUT (
    .clock(clock), .reset(reset), .request_valid(request_valid), .request(request),
    .busy(busy), .reply_valid(reply_valid), .reply(reply), .reply_ready(reply_ready),
    .runway_active(runway_active)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // Random numbers and message helpers
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic atc_pkg::msg_t make_msg(input logic [`ATC_PLANE_ID_W-1:0] id,
                                             input atc_pkg::msg_type_t t,
                                             input logic [1:0] a);
    atc_pkg::msg_t m;
    m.plane_id   = id;
    m.msg_type   = t;
    m.msg_action = a;
    return m;
  endfunction

  // Mix of requests, declarations, emergencies and invalid types
  function automatic atc_pkg::msg_t random_request();
    logic [2:0]                 sel;
    logic [2:0]                 t;
    logic [`ATC_PLANE_ID_W-1:0] plane;
    logic                       rw;
    logic [1:0]                 act;
    sel   = 3'(random_bits(3));
    plane = `ATC_PLANE_ID_W'(random_bits(`ATC_PLANE_ID_W));
    if (sel <= 3'd2) begin
      rw = 1'(random_bits(1));
      return make_msg(plane, atc_pkg::T_REQUEST, {rw, 1'b0});
    end else if (sel <= 3'd5) begin
      rw = 1'(random_bits(1));
      // Half of the declarations come from the owner
      if (1'(random_bits(1))) begin
        plane = owner[rw];
      end
      return make_msg(plane, atc_pkg::T_DECLARE, {1'b0, rw});
    end else if (sel == 3'd6) begin
      act = 2'(random_bits(2));
      return make_msg(plane, atc_pkg::T_EMERGENCY, act);
    end
    t = 3'(random_bits(3));
    if (t < 3'd3) begin
      t = t + 3'd3;
    end
    act = 2'(random_bits(2));
    return atc_pkg::msg_t'({plane, t, act});
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // One queue pass per loop, until nothing more can move
  task automatic serve_queues();
    logic                       moved;
    logic                       rw;
    logic [`ATC_PLANE_ID_W-1:0] id;
    moved = 1'b1;
    while (moved) begin
      moved = 1'b0;
      rw    = active[0];
      if (emergency_flag && landing_q.size() != 0) begin
        id = landing_q.pop_front();
        expected.push_back(make_msg(id, atc_pkg::T_DIVERT, 2'b00));
        moved = 1'b1;
      end else if (active != '1) begin
        if (takeoff_q.size() != 0 && (takeoff_first || landing_q.size() == 0)) begin
          id    = takeoff_q.pop_front();
          moved = 1'b1;
        end else if (landing_q.size() != 0) begin
          id    = landing_q.pop_front();
          moved = 1'b1;
        end
        if (moved) begin
          owner[rw]     = id;
          active[rw]    = 1'b1;
          takeoff_first = !takeoff_first;
          expected.push_back(make_msg(id, atc_pkg::T_CLEAR, {1'b0, rw}));
        end
      end
    end
  endtask

  task automatic model_request(input atc_pkg::msg_t r);
    logic rw;
    rw = r.msg_action[0];
    case (r.msg_type)
      atc_pkg::T_REQUEST: begin
        if (!r.msg_action[1]) begin
          if (takeoff_q.size() == `ATC_PLANE_DEPTH) begin
            expected.push_back(make_msg(r.plane_id, atc_pkg::T_DIVERT, 2'b00));
          end else begin
            takeoff_q.push_back(r.plane_id);
            expected.push_back(make_msg(r.plane_id, atc_pkg::T_HOLD, 2'b00));
          end
        end else if (landing_q.size() == `ATC_PLANE_DEPTH || emergency_flag) begin
          expected.push_back(make_msg(r.plane_id, atc_pkg::T_DIVERT, 2'b00));
        end else begin
          landing_q.push_back(r.plane_id);
          expected.push_back(make_msg(r.plane_id, atc_pkg::T_HOLD, 2'b00));
        end
      end
      atc_pkg::T_DECLARE: begin
        if (active[rw] && owner[rw] == r.plane_id) begin
          active[rw] = 1'b0;
        end
      end
      atc_pkg::T_EMERGENCY: begin
        if (r.msg_action == 2'b01) begin
          emergency_flag = 1'b1;
        end else if (r.msg_action == 2'b00) begin
          emergency_flag = 1'b0;
        end else begin
          expected.push_back(make_msg(r.plane_id, atc_pkg::T_SAY_AGAIN, 2'b00));
        end
      end
      default: expected.push_back(make_msg(r.plane_id, atc_pkg::T_SAY_AGAIN, 2'b00));
    endcase
    serve_queues();
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_reply(input atc_pkg::msg_t actual, input atc_pkg::msg_t exp);
    checks++;
    if (actual !== exp) begin
      errors++;
      $display("Fail reply: got 0x%h expected 0x%h", actual, exp);
    end
  endtask

  task automatic check_runways(input logic [`ATC_RUNWAYS-1:0] actual,
                               input logic [`ATC_RUNWAYS-1:0] exp);
    checks++;
    if (actual !== exp) begin
      errors++;
      $display("Fail runway_active: got 0x%h expected 0x%h", actual, exp);
    end
  endtask

  task automatic check_busy(input logic actual, input logic exp);
    checks++;
    if (actual !== exp) begin
      errors++;
      $display("Fail busy: got 0x%h expected 0x%h", actual, exp);
    end
  endtask

  // Reply monitor, outputs are stable at the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      if (reply_valid) begin
        quiet_cycles = 0;
        if (!ready_seen) begin
          errors++;
          $display("Error: reply left although reply_ready was low when it was popped");
        end
        if (valid_seen) begin
          errors++;
          $display("Error: replies strobed in back-to-back cycles");
        end
        if (expected.size() == 0) begin
          errors++;
          $display("Error: DUT sent reply 0x%h that the model did not predict", reply);
        end else begin
          check_reply(reply, expected.pop_front());
        end
      end else begin
        quiet_cycles++;
      end
      ready_seen = reply_ready;
      valid_seen = reply_valid;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count == CYCLE_LIMIT) begin
      $display("Error: run timed out after %0d cycles", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Waits for all predicted replies, then for 40 cycles without a reply
  task automatic wait_settled();
    int   spell;
    logic level;
    spell = 0;
    level = 1'b1;
    while (expected.size() != 0 || quiet_cycles < 40) begin
      @(posedge clock);
      if (ready_random) begin
        if (spell == 0) begin
          level = 1'(random_bits(1));
          spell = int'(random_bits(2)) + 1;
        end
        spell--;
        reply_ready <= level;
      end else begin
        reply_ready <= 1'b1;
      end
    end
  endtask

  task automatic send_request(input atc_pkg::msg_t r);
    @(posedge clock);
    request_valid <= 1'b1;
    request       <= r;
    quiet_cycles = 0;
    model_request(r);
    @(posedge clock);
    request_valid <= 1'b0;
    wait_settled();
    check_runways(runway_active, active);
  endtask

  // Invalid requests on back-to-back cycles until the request FIFO is full
  task automatic fill_requests();
    atc_pkg::msg_t r;
    logic          seen_busy;
    seen_busy    = 1'b0;
    quiet_cycles = 0;
    for (int i = 0; i < FILL_REQUESTS && !seen_busy; i++) begin
      r = atc_pkg::msg_t'({4'(i), 3'd3, 2'b00});
      @(posedge clock);
      request_valid <= 1'b1;
      request       <= r;
      // busy only moves on a rising edge, so this is its value at the write
      @(negedge clock);
      if (busy) begin
        seen_busy = 1'b1;
      end else begin
        model_request(r);
      end
    end
    @(posedge clock);
    request_valid <= 1'b0;
    if (!seen_busy) begin
      errors++;
      $display("Error: busy never rose while requests arrived every cycle");
    end
    wait_settled();
    check_busy(busy, 1'b0);
    check_runways(runway_active, active);
  endtask

  task automatic request_takeoff(input logic [`ATC_PLANE_ID_W-1:0] id);
    send_request(make_msg(id, atc_pkg::T_REQUEST, 2'b00));
  endtask

  task automatic request_landing(input logic [`ATC_PLANE_ID_W-1:0] id);
    send_request(make_msg(id, atc_pkg::T_REQUEST, 2'b10));
  endtask

  task automatic declare_runway(input logic [`ATC_PLANE_ID_W-1:0] id, input logic rw);
    send_request(make_msg(id, atc_pkg::T_DECLARE, {1'b0, rw}));
  endtask

  task automatic send_emergency(input logic [`ATC_PLANE_ID_W-1:0] id, input logic [1:0] a);
    send_request(make_msg(id, atc_pkg::T_EMERGENCY, a));
  endtask

  task automatic report_test(input string name);
    if (errors == errors_before) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  initial begin
    reset          = 1'b1;
    request_valid  = 1'b0;
    request        = '0;
    reply_ready    = 1'b1;
    active         = '0;
    emergency_flag = 1'b0;
    takeoff_first  = 1'b1;
    errors_before  = 0;
    for (int i = 0; i < `ATC_RUNWAYS; i++) begin
      owner[i] = '0;
    end
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    request_takeoff(4'd1);
    report_test("takeoff clearance");

    // Plane 3 waits until the owner of runway 0 declares
    request_takeoff(4'd2);
    request_takeoff(4'd3);
    declare_runway(4'd5, 1'b0);
    declare_runway(4'd1, 1'b0);
    report_test("runway ownership");

    send_request(atc_pkg::msg_t'({4'd7, 3'd3, 2'b00}));
    for (int id = 8; id <= 12; id++) begin
      request_takeoff(4'(id));
    end
    send_emergency(4'd4, 2'b11);
    declare_runway(4'd3, 1'b0);
    declare_runway(4'd2, 1'b1);
    declare_runway(4'd8, 1'b0);
    declare_runway(4'd9, 1'b1);
    declare_runway(4'd10, 1'b0);
    declare_runway(4'd11, 1'b1);
    report_test("say again and divert");

    request_takeoff(4'd1);
    request_takeoff(4'd2);
    request_landing(4'd3);
    request_landing(4'd4);
    send_emergency(4'd0, 2'b01);
    request_landing(4'd5);
    request_takeoff(4'd6);
    declare_runway(4'd1, 1'b0);
    request_landing(4'd7);
    send_emergency(4'd0, 2'b00);
    request_landing(4'd7);
    declare_runway(4'd2, 1'b1);
    declare_runway(4'd6, 1'b0);
    declare_runway(4'd7, 1'b1);
    report_test("emergency");

    fill_requests();
    report_test("request FIFO full");

    ready_random = 1'b1;
    repeat (READY_REQUESTS) send_request(random_request());
    ready_random = 1'b0;
    @(posedge clock);
    reply_ready <= 1'b1;
    report_test("reply back-pressure");

    repeat (RANDOM_REQUESTS) send_request(random_request());
    report_test("random requests");

    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/atc_defs.svh
// Shared size constants for the air traffic controller core.
// Include this header in any file that sizes ports, queues or runways.

`ifndef ATC_DEFS_SVH
`define ATC_DEFS_SVH

// Plane id and message widths
`define ATC_PLANE_ID_W 4
`define ATC_MSG_W 9

// Request and reply FIFO depth
`define ATC_REQ_DEPTH 4

// Takeoff and landing queue depth
`define ATC_PLANE_DEPTH 4

// Runways under control
`define ATC_RUNWAYS 2

`endif

//--- verilog/atc_pkg.sv
// Message, runway and command types shared by the controller modules.
// Modules refer to these with atc_pkg:: scoped names.

`include "atc_defs.svh"

package atc_pkg;

  // Incoming types are 0..2, anything from 3 up is invalid on input
  typedef enum logic [2:0] {
    T_REQUEST   = 3'd0,
    T_DECLARE   = 3'd1,
    T_EMERGENCY = 3'd2,
    T_CLEAR     = 3'd4,
    T_HOLD      = 3'd5,
    T_SAY_AGAIN = 3'd6,
    T_DIVERT    = 3'd7
  } msg_type_t;

  // Request and reply message, plane id in the top bits
  typedef struct packed {
    logic [`ATC_PLANE_ID_W-1:0] plane_id;
    msg_type_t                  msg_type;
    logic [1:0]                 msg_action;
  } msg_t;

  // Owner and lock flag of one runway
  typedef struct packed {
    logic [`ATC_PLANE_ID_W-1:0] plane_id;
    logic                       active;
  } runway_t;

  typedef enum logic [2:0] {
    R_NONE,
    R_HOLD,
    R_SAY_AGAIN,
    R_DIVERT,
    R_CLEAR_TAKEOFF,
    R_CLEAR_LANDING,
    R_DIVERT_LANDING
  } reply_cmd_t;

  // One-cycle runway command from the FSM
  typedef struct packed {
    logic lock;
    logic unlock;
    logic runway_id;
    logic spare;
  } runway_cmd_t;

endpackage

//--- verilog/atc_top.sv
// Two-runway air traffic controller core.
// Requests enter on a strobe, replies leave on a strobe paced by reply_ready.
// busy is high while the request FIFO is full.

`timescale 1ns/1ps
`include "atc_defs.svh"

module atc_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    request_valid,
  input  atc_pkg::msg_t           request,
  output logic                    busy,
  output logic                    reply_valid,
  output atc_pkg::msg_t           reply,
  input  logic                    reply_ready,
  output logic [`ATC_RUNWAYS-1:0] runway_active
);

  atc_pkg::msg_t                current_request;
  atc_pkg::msg_t                next_reply;
  atc_pkg::reply_cmd_t          reply_cmd;
  atc_pkg::runway_cmd_t         runway_cmd;
  logic [`ATC_PLANE_ID_W-1:0]   takeoff_id;
  logic [`ATC_PLANE_ID_W-1:0]   landing_id;
  logic [`ATC_PLANE_ID_W-1:0]   table_plane_id;
  logic request_read, request_empty;
  logic takeoff_write, takeoff_read, takeoff_full, takeoff_empty;
  logic landing_write, landing_read, landing_full, landing_empty;
  logic queue_reply, reply_read, reply_full, reply_empty;
  logic emergency, emergency_set, emergency_clear;

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  plane_fifo #(.WIDTH(`ATC_MSG_W), .DEPTH(`ATC_REQ_DEPTH)) request_fifo (
    .clock(clock), .reset(reset), .data_in(request), .write(request_valid),
    .read(request_read), .data_out(current_request), .full(busy), .empty(request_empty)
  );

  plane_fifo #(.WIDTH(`ATC_PLANE_ID_W), .DEPTH(`ATC_PLANE_DEPTH)) takeoff_fifo (
    .clock(clock), .reset(reset), .data_in(current_request.plane_id),
    .write(takeoff_write), .read(takeoff_read), .data_out(takeoff_id),
    .full(takeoff_full), .empty(takeoff_empty)
  );

  plane_fifo #(.WIDTH(`ATC_PLANE_ID_W), .DEPTH(`ATC_PLANE_DEPTH)) landing_fifo (
    .clock(clock), .reset(reset), .data_in(current_request.plane_id),
    .write(landing_write), .read(landing_read), .data_out(landing_id),
    .full(landing_full), .empty(landing_empty)
  );

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  request_fsm fsm (
    .clock(clock), .reset(reset), .request(current_request),
    .request_empty(request_empty), .request_read(request_read),
    .takeoff_full(takeoff_full), .takeoff_empty(takeoff_empty),
    .takeoff_write(takeoff_write), .takeoff_read(takeoff_read),
    .landing_full(landing_full), .landing_empty(landing_empty),
    .landing_write(landing_write), .landing_read(landing_read),
    .reply_full(reply_full), .queue_reply(queue_reply),
    .runway_active(runway_active), .emergency(emergency),
    .reply_cmd(reply_cmd), .runway_cmd(runway_cmd),
    .emergency_set(emergency_set), .emergency_clear(emergency_clear)
  );

  // Locks record the cleared plane, declarations compare the requesting plane
  assign table_plane_id = !runway_cmd.lock ? current_request.plane_id :
                          (reply_cmd == atc_pkg::R_CLEAR_LANDING) ? landing_id : takeoff_id;

  runway_table runways (
    .clock(clock), .reset(reset), .plane_id(table_plane_id),
    .runway_cmd(runway_cmd), .runway_active(runway_active)
  );

  // Emergency latch, a set wins over a clear
  always_ff @(posedge clock) begin
    if (reset) begin
      emergency <= 1'b0;
    end else if (emergency_set) begin
      emergency <= 1'b1;
    end else if (emergency_clear) begin
      emergency <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Reply path
  //////////////////////////////////////////////////

  reply_builder builder (
    .clock(clock), .reset(reset), .reply_cmd(reply_cmd), .request(current_request),
    .takeoff_id(takeoff_id), .landing_id(landing_id),
    .runway_id(runway_cmd.runway_id), .reply(next_reply)
  );

  plane_fifo #(.WIDTH(`ATC_MSG_W), .DEPTH(`ATC_REQ_DEPTH)) reply_fifo (
    .clock(clock), .reset(reset), .data_in(next_reply), .write(queue_reply),
    .read(reply_read), .data_out(reply), .full(reply_full), .empty(reply_empty)
  );

  reply_sender sender (
    .clock(clock), .reset(reset), .reply_empty(reply_empty),
    .reply_ready(reply_ready), .reply_read(reply_read), .reply_valid(reply_valid)
  );

endmodule

//--- verilog/plane_fifo.sv
// Circular FIFO with an occupancy counter and a registered read port.
// Read data shows on data_out the cycle after read and holds until the next read.

`timescale 1ns/1ps

module plane_fifo #(
  parameter int WIDTH = 4,
  parameter int DEPTH = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic [WIDTH-1:0] data_in,
  input  logic             write,
  input  logic             read,
  output logic [WIDTH-1:0] data_out,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] put_ptr;
  logic [PTR_W-1:0] get_ptr;
  logic [PTR_W:0]   count;
  logic             do_write;
  logic             do_read;

  assign empty    = (count == '0);
  assign full     = (count == (PTR_W+1)'(DEPTH));
  assign do_write = write && !full;
  assign do_read  = read && !empty;

  always_ff @(posedge clock) begin
    if (reset) begin
      put_ptr <= '0;
      get_ptr <= '0;
      count   <= '0;
    end else begin
      if (do_write) begin
        put_ptr <= (put_ptr == PTR_W'(DEPTH - 1)) ? '0 : put_ptr + 1'b1;
      end
      if (do_read) begin
        get_ptr <= (get_ptr == PTR_W'(DEPTH - 1)) ? '0 : get_ptr + 1'b1;
      end
      // Read and write together leave the count alone
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and read register
  always_ff @(posedge clock) begin
    if (do_write) begin
      mem[put_ptr] <= data_in;
    end
    if (do_read) begin
      data_out <= mem[get_ptr];
    end
  end

endmodule

//--- verilog/reply_builder.sv
// Reply register, loaded one clock after the FSM issues a reply command.
// Holds its value while the command is R_NONE.

`timescale 1ns/1ps
`include "atc_defs.svh"

module reply_builder (
  input  logic                        clock,
  input  logic                        reset,
  input  atc_pkg::reply_cmd_t         reply_cmd,
  input  atc_pkg::msg_t               request,
  input  logic [`ATC_PLANE_ID_W-1:0]  takeoff_id,
  input  logic [`ATC_PLANE_ID_W-1:0]  landing_id,
  input  logic                        runway_id,
  output atc_pkg::msg_t               reply
);

  always_ff @(posedge clock) begin
    if (reset) begin
      reply <= '0;
    end else begin
      case (reply_cmd)
        // Replies to the request being handled
        atc_pkg::R_HOLD: begin
          reply <= '{request.plane_id, atc_pkg::T_HOLD, 2'b00};
        end
        atc_pkg::R_SAY_AGAIN: begin
          reply <= '{request.plane_id, atc_pkg::T_SAY_AGAIN, 2'b00};
        end
        atc_pkg::R_DIVERT: begin
          reply <= '{request.plane_id, atc_pkg::T_DIVERT, 2'b00};
        end
        // Replies to planes just taken off a queue
        atc_pkg::R_CLEAR_TAKEOFF: begin
          reply <= '{takeoff_id, atc_pkg::T_CLEAR, {1'b0, runway_id}};
        end
        atc_pkg::R_CLEAR_LANDING: begin
          reply <= '{landing_id, atc_pkg::T_CLEAR, {1'b0, runway_id}};
        end
        atc_pkg::R_DIVERT_LANDING: begin
          reply <= '{landing_id, atc_pkg::T_DIVERT, 2'b00};
        end
        default: begin
          reply <= reply;
        end
      endcase
    end
  end

endmodule

//--- verilog/reply_sender.sv
// Reply pacer between the reply FIFO and the reply port.
// Pops one reply when ready is high and strobes it out the next cycle.

`timescale 1ns/1ps

module reply_sender (
  input  logic clock,
  input  logic reset,
  input  logic reply_empty,
  input  logic reply_ready,
  output logic reply_read,
  output logic reply_valid
);

  typedef enum logic {
    WAIT,
    SEND
  } state_t;

  state_t state;
  state_t next_state;

  always_comb begin
    next_state  = state;
    reply_read  = 1'b0;
    reply_valid = 1'b0;
    case (state)
      WAIT: begin
        if (!reply_empty && reply_ready) begin
          reply_read = 1'b1;
          next_state = SEND;
        end
      end
      // FIFO data_out carries the popped reply here
      SEND: begin
        reply_valid = 1'b1;
        next_state  = WAIT;
      end
      default: next_state = WAIT;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= WAIT;
    end else begin
      state <= next_state;
    end
  end

endmodule

//--- verilog/request_fsm.sv
// Request interpreter and queue scheduler of the controller.
// Reads one request at a time, queues or rejects planes, unlocks runways,
// handles emergencies and clears queued planes onto free runways.

`timescale 1ns/1ps
`include "atc_defs.svh"

module request_fsm (
  input  logic                        clock,
  input  logic                        reset,
  input  atc_pkg::msg_t               request,
  input  logic                        request_empty,
  output logic                        request_read,
  input  logic                        takeoff_full,
  input  logic                        takeoff_empty,
  output logic                        takeoff_write,
  output logic                        takeoff_read,
  input  logic                        landing_full,
  input  logic                        landing_empty,
  output logic                        landing_write,
  output logic                        landing_read,
  input  logic                        reply_full,
  output logic                        queue_reply,
  input  logic [`ATC_RUNWAYS-1:0]     runway_active,
  input  logic                        emergency,
  output atc_pkg::reply_cmd_t         reply_cmd,
  output atc_pkg::runway_cmd_t        runway_cmd,
  output logic                        emergency_set,
  output logic                        emergency_clear
);

  typedef enum logic [2:0] {
    QUIET,
    INTERPRET,
    REPLY,
    CHECK_QUEUES,
    CLR_TAKEOFF,
    CLR_LANDING,
    DIVERT_LANDING,
    QUEUE_CLR
  } state_t;

  state_t state;
  state_t next_state;

  // Set when takeoffs win the next tie between both queues
  logic takeoff_first;
  logic runway_free;
  logic free_runway;
  logic takeoff_ok;
  logic landing_ok;

  assign runway_free = ~&runway_active;
  // Runway 0 is taken first
  assign free_runway = runway_active[0];
  assign takeoff_ok  = !takeoff_empty;
  assign landing_ok  = !landing_empty && !emergency;

  //////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////

  always_comb begin
    next_state      = state;
    request_read    = 1'b0;
    takeoff_write   = 1'b0;
    takeoff_read    = 1'b0;
    landing_write   = 1'b0;
    landing_read    = 1'b0;
    queue_reply     = 1'b0;
    reply_cmd       = atc_pkg::R_NONE;
    runway_cmd      = '0;
    emergency_set   = 1'b0;
    emergency_clear = 1'b0;

    case (state)
      QUIET: begin
        if (!request_empty) begin
          request_read = 1'b1;
          next_state   = INTERPRET;
        end else begin
          next_state = CHECK_QUEUES;
        end
      end

      INTERPRET: begin
        case (request.msg_type)
          atc_pkg::T_REQUEST: begin
            next_state = REPLY;
            if (!request.msg_action[1]) begin
              if (takeoff_full) begin
                reply_cmd = atc_pkg::R_DIVERT;
              end else begin
                takeoff_write = 1'b1;
                reply_cmd     = atc_pkg::R_HOLD;
              end
            end else if (landing_full || emergency) begin
              reply_cmd = atc_pkg::R_DIVERT;
            end else begin
              landing_write = 1'b1;
              reply_cmd     = atc_pkg::R_HOLD;
            end
          end

          atc_pkg::T_DECLARE: begin
            // Owner check happens in the runway table
            runway_cmd.unlock    = 1'b1;
            runway_cmd.runway_id = request.msg_action[0];
            next_state           = CHECK_QUEUES;
          end

          atc_pkg::T_EMERGENCY: begin
            if (request.msg_action == 2'b01) begin
              emergency_set = 1'b1;
              next_state    = CHECK_QUEUES;
            end else if (request.msg_action == 2'b00) begin
              emergency_clear = 1'b1;
              next_state      = CHECK_QUEUES;
            end else begin
              reply_cmd  = atc_pkg::R_SAY_AGAIN;
              next_state = REPLY;
            end
          end

          default: begin
            reply_cmd  = atc_pkg::R_SAY_AGAIN;
            next_state = REPLY;
          end
        endcase
      end

      // Reply register is loaded, wait for room in the reply FIFO
      REPLY: begin
        if (!reply_full) begin
          queue_reply = 1'b1;
          next_state  = CHECK_QUEUES;
        end
      end

      CHECK_QUEUES: begin
        next_state = QUIET;
        if (emergency && !landing_empty) begin
          landing_read = 1'b1;
          next_state   = DIVERT_LANDING;
        end else if (runway_free) begin
          if (takeoff_ok && (takeoff_first || !landing_ok)) begin
            takeoff_read = 1'b1;
            next_state   = CLR_TAKEOFF;
          end else if (landing_ok) begin
            landing_read = 1'b1;
            next_state   = CLR_LANDING;
          end
        end
      end

      CLR_TAKEOFF: begin
        runway_cmd.lock      = 1'b1;
        runway_cmd.runway_id = free_runway;
        reply_cmd            = atc_pkg::R_CLEAR_TAKEOFF;
        next_state           = QUEUE_CLR;
      end

      CLR_LANDING: begin
        runway_cmd.lock      = 1'b1;
        runway_cmd.runway_id = free_runway;
        reply_cmd            = atc_pkg::R_CLEAR_LANDING;
        next_state           = QUEUE_CLR;
      end

      DIVERT_LANDING: begin
        reply_cmd  = atc_pkg::R_DIVERT_LANDING;
        next_state = QUEUE_CLR;
      end

      QUEUE_CLR: begin
        if (!reply_full) begin
          queue_reply = 1'b1;
          next_state  = QUIET;
        end
      end

      default: next_state = QUIET;
    endcase
  end

  //////////////////////////////////////////////////
  // State and priority registers
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= QUIET;
      takeoff_first <= 1'b1;
    end else begin
      state <= next_state;
      // Priority flips once per clearance
      if (state == CLR_TAKEOFF || state == CLR_LANDING) begin
        takeoff_first <= ~takeoff_first;
      end
    end
  end

endmodule

//--- verilog/runway_table.sv
// Lock and owner registers for each runway.
// A lock records the plane, an unlock only frees the runway for its owner.

`timescale 1ns/1ps
`include "atc_defs.svh"

module runway_table (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [`ATC_PLANE_ID_W-1:0]  plane_id,
  input  atc_pkg::runway_cmd_t        runway_cmd,
  output logic [`ATC_RUNWAYS-1:0]     runway_active
);

  atc_pkg::runway_t runway [`ATC_RUNWAYS];

  always_comb begin
    for (int i = 0; i < `ATC_RUNWAYS; i++) begin
      runway_active[i] = runway[i].active;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `ATC_RUNWAYS; i++) begin
        runway[i].active <= 1'b0;
      end
    end else if (runway_cmd.lock) begin
      runway[runway_cmd.runway_id].plane_id <= plane_id;
      runway[runway_cmd.runway_id].active   <= 1'b1;
    end else if (runway_cmd.unlock) begin
      // Other planes cannot release a runway
      if (plane_id == runway[runway_cmd.runway_id].plane_id) begin
        runway[runway_cmd.runway_id].active <= 1'b0;
      end
    end
  end

endmodule
